//--- logic/chess_pkg.sv
package chess_pkg;

    ////////////////////////////////////////////////////////////////////
    // board encoding

    typedef logic [5:0] square_idx_t;   // row * 8 + column, row 0 is black back rank
    typedef logic [2:0] piece_t;
    typedef logic       side_t;

    localparam piece_t PIECE_EMPTY  = 3'd0;
    localparam piece_t PIECE_PAWN   = 3'd1;
    localparam piece_t PIECE_BISHOP = 3'd2;
    localparam piece_t PIECE_KNIGHT = 3'd3;
    localparam piece_t PIECE_ROOK   = 3'd4;
    localparam piece_t PIECE_QUEEN  = 3'd5;
    localparam piece_t PIECE_KING   = 3'd6;

    localparam side_t SIDE_WHITE = 1'b0;
    localparam side_t SIDE_BLACK = 1'b1;

    typedef struct packed {
        side_t  side;
        piece_t piece;
    } square_t;

    typedef struct packed {
        logic        valid;
        square_idx_t from;
        square_idx_t to;
        square_t     placed;
    } move_cmd_t;

    typedef logic [63:0] avail_mask_t;  // one bit per square index

    ////////////////////////////////////////////////////////////////////
    // display

    typedef logic [15:0] rgb565_t;
    typedef logic [12:0] pixel_idx_t;

    localparam rgb565_t COL_MARGIN      = 16'h0000;
    localparam rgb565_t COL_LIGHT_SQ    = 16'hFFFF;
    localparam rgb565_t COL_DARK_SQ     = 16'h9262;   // brown
    localparam rgb565_t COL_AVAIL       = 16'hF7E2;   // yellow
    localparam rgb565_t COL_WHITE_PIECE = 16'h26DD;   // drawn blue
    localparam rgb565_t COL_BLACK_PIECE = 16'h0000;

    ////////////////////////////////////////////////////////////////////
    // APB

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

    localparam logic [11:0] REG_CTRL        = 12'h000;  // bit 0 viewing player
    localparam logic [11:0] REG_MOVE        = 12'h004;
    localparam logic [11:0] REG_AVAIL_LO    = 12'h008;
    localparam logic [11:0] REG_AVAIL_HI    = 12'h00C;
    localparam logic [11:0] REG_SQUARE_BASE = 12'h100;  // read only, base + 4 * index

endpackage

//--- logic/piece_glyph_rom.sv
`timescale 1ns/1ns

module piece_glyph_rom
    import chess_pkg::*;
(
    input  piece_t     piece,
    input  logic [2:0] glyph_row,
    output logic [7:0] row_bits
);

    // rows listed 7 down to 0, bit k of a row is column k
    localparam logic [7:0][7:0] PAWN_ART = {
        8'h7E, 8'h18, 8'h18, 8'h18, 8'h3C, 8'h3C, 8'h18, 8'h00
    };
    localparam logic [7:0][7:0] BISHOP_ART = {
        8'h7E, 8'h3C, 8'h7E, 8'h6E, 8'h5E, 8'h3C, 8'h18, 8'h00
    };
    localparam logic [7:0][7:0] KNIGHT_ART = {
        8'h7E, 8'h38, 8'h72, 8'h7E, 8'h7A, 8'h3C, 8'h08, 8'h00
    };
    localparam logic [7:0][7:0] ROOK_ART = {
        8'h7E, 8'h3C, 8'h18, 8'h18, 8'h7E, 8'h7E, 8'h5A, 8'h00
    };
    localparam logic [7:0][7:0] QUEEN_ART = {
        8'h7E, 8'h18, 8'h3C, 8'h5A, 8'h5A, 8'h7E, 8'h18, 8'h00
    };
    localparam logic [7:0][7:0] KING_ART = {
        8'h7E, 8'h3C, 8'h7E, 8'h5A, 8'h5A, 8'h00, 8'h5A, 8'h00   // row 2 left open
    };

    always_comb
    begin
        case (piece)
            PIECE_PAWN:   row_bits = PAWN_ART[glyph_row];
            PIECE_BISHOP: row_bits = BISHOP_ART[glyph_row];
            PIECE_KNIGHT: row_bits = KNIGHT_ART[glyph_row];
            PIECE_ROOK:   row_bits = ROOK_ART[glyph_row];
            PIECE_QUEEN:  row_bits = QUEEN_ART[glyph_row];
            PIECE_KING:   row_bits = KING_ART[glyph_row];
            default:      row_bits = 8'h00;     // empty and spare code
        endcase
    end

endmodule

//--- logic/pixel_renderer.sv
`timescale 1ns/1ns

module pixel_renderer
    import chess_pkg::*;
#(
    parameter int SCREEN_WIDTH = 96,
    parameter int BOARD_LEFT   = 16
)
(
    input  logic        clock,
    input  logic        rst_n,
    input  logic        pixel_req,
    input  pixel_idx_t  pixel_index,
    input  logic        player,
    input  avail_mask_t avail,
    output square_idx_t sq_addr,
    input  square_t     sq_data,
    output logic        pixel_valid,
    output rgb565_t     pixel_colour
);

    ////////////////////////////////////////////////////////////////////
    // stage 1: index to square

    pixel_idx_t  x;
    pixel_idx_t  y;
    pixel_idx_t  board_x;
    logic [2:0]  col;
    logic [2:0]  row;
    square_idx_t screen_sq;

    assign x       = pixel_idx_t'(pixel_index % SCREEN_WIDTH);
    assign y       = pixel_idx_t'(pixel_index / SCREEN_WIDTH);
    assign board_x = x - pixel_idx_t'(BOARD_LEFT);
    assign col     = board_x[5:3];
    assign row     = y[5:3];

    assign screen_sq = {row, col};
    assign sq_addr   = player ? (6'd63 - screen_sq) : screen_sq;   // second player view

    logic       s1_valid;
    logic       s1_margin;
    logic       s1_avail;
    logic       s1_dark;
    square_t    s1_square;
    logic [2:0] s1_glyph_row;
    logic [2:0] s1_glyph_col;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
            s1_valid <= 1'b0;
        else
            s1_valid <= pixel_req;
    end

    always_ff @(posedge clock)
    begin
        s1_margin    <= (x < BOARD_LEFT) || (x >= BOARD_LEFT + 64);
        s1_avail     <= avail[sq_addr];
        s1_dark      <= row[0] ^ col[0];    // odd row + col
        s1_square    <= sq_data;
        s1_glyph_row <= y[2:0];
        s1_glyph_col <= x[2:0];
    end

    ////////////////////////////////////////////////////////////////////
    // stage 2: glyph lookup and colour pick

    logic [7:0] row_bits;
    rgb565_t    colour;

    piece_glyph_rom u_glyph_rom (
        .piece     (s1_square.piece),
        .glyph_row (s1_glyph_row),
        .row_bits  (row_bits)
    );

    always_comb
    begin
        if (s1_margin)
            colour = COL_MARGIN;
        else if (s1_avail)
            colour = COL_AVAIL;                 // highlight hides the piece
        else if (s1_square.piece != PIECE_EMPTY && row_bits[s1_glyph_col])
            colour = (s1_square.side == SIDE_BLACK) ? COL_BLACK_PIECE : COL_WHITE_PIECE;
        else if (s1_dark)
            colour = COL_DARK_SQ;
        else
            colour = COL_LIGHT_SQ;
    end

    always_ff @(posedge clock)
    begin
        if (!rst_n)
            pixel_valid <= 1'b0;
        else
            pixel_valid <= s1_valid;
    end

    always_ff @(posedge clock)
    begin
        pixel_colour <= colour;
    end

endmodule

//--- logic/board_state.sv
`timescale 1ns/1ns

module board_state
    import chess_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  move_cmd_t   move,
    input  square_idx_t bus_sq_addr,
    output square_t     bus_sq_data,
    input  square_idx_t render_sq_addr,
    output square_t     render_sq_data
);

    square_t squares [64];

    // back rank order, same for both sides
    function automatic piece_t back_rank(logic [2:0] col);
        piece_t p;
        case (col)
            3'd0, 3'd7: p = PIECE_ROOK;
            3'd1, 3'd6: p = PIECE_KNIGHT;
            3'd2, 3'd5: p = PIECE_BISHOP;
            3'd3:       p = PIECE_KING;
            default:    p = PIECE_QUEEN;
        endcase
        return p;
    endfunction

    function automatic square_t start_square(square_idx_t idx);
        square_t sq;
        sq = '{side: SIDE_WHITE, piece: PIECE_EMPTY};
        case (idx[5:3])
            3'd0:    sq = '{side: SIDE_BLACK, piece: back_rank(idx[2:0])};
            3'd1:    sq = '{side: SIDE_BLACK, piece: PIECE_PAWN};
            3'd6:    sq = '{side: SIDE_WHITE, piece: PIECE_PAWN};
            3'd7:    sq = '{side: SIDE_WHITE, piece: back_rank(idx[2:0])};
            default: sq = '{side: SIDE_WHITE, piece: PIECE_EMPTY};
        endcase
        return sq;
    endfunction

    ////////////////////////////////////////////////////////////////////
    // square store

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 64; i++)
                squares[i] <= start_square(square_idx_t'(i));
        end
        else if (move.valid)
        begin
            squares[move.from] <= '{side: SIDE_WHITE, piece: PIECE_EMPTY};
            squares[move.to]   <= move.placed;    // later write wins when from == to
        end
    end

    assign bus_sq_data    = squares[bus_sq_addr];
    assign render_sq_data = squares[render_sq_addr];

endmodule

//--- logic/apb_board_regs.sv
`timescale 1ns/1ns

module apb_board_regs
    import chess_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  apb_req_t    apb_req,
    output apb_rsp_t    apb_rsp,
    output move_cmd_t   move,
    output avail_mask_t avail,
    output logic        player,
    output square_idx_t bus_sq_addr,
    input  square_t     bus_sq_data
);

    logic        access;
    logic        sq_hit;
    logic        wr_ok;
    logic        rd_ok;
    logic [31:0] rd_data;

    logic        player_q;
    logic [31:0] avail_lo;
    logic [31:0] avail_hi;
    logic        move_valid;
    square_idx_t move_from;
    square_idx_t move_to;
    square_t     move_placed;

    assign access = apb_req.psel && apb_req.penable;

    // square window 0x100..0x1FC, word aligned
    assign sq_hit      = (apb_req.paddr[11:8] == REG_SQUARE_BASE[11:8]) &&
                         (apb_req.paddr[1:0] == 2'b00);
    assign bus_sq_addr = apb_req.paddr[7:2];

    ////////////////////////////////////////////////////////////////////
    // read mux and error decode

    always_comb
    begin
        rd_data = '0;
        wr_ok   = 1'b1;
        rd_ok   = 1'b1;
        case (apb_req.paddr)
            REG_CTRL:     rd_data = {31'b0, player_q};
            REG_MOVE:     rd_data = '0;            // command strobe, reads zero
            REG_AVAIL_LO: rd_data = avail_lo;
            REG_AVAIL_HI: rd_data = avail_hi;
            default:
            begin
                wr_ok = 1'b0;                      // squares are read only
                if (sq_hit)
                    rd_data = {28'b0, bus_sq_data};
                else
                    rd_ok = 1'b0;
            end
        endcase
    end

    assign apb_rsp.pready  = 1'b1;                 // no wait states
    assign apb_rsp.prdata  = rd_data;
    assign apb_rsp.pslverr = access && (apb_req.pwrite ? !wr_ok : !rd_ok);

    ////////////////////////////////////////////////////////////////////
    // register writes

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            player_q   <= 1'b0;
            avail_lo   <= '0;
            avail_hi   <= '0;
            move_valid <= 1'b0;
        end
        else
        begin
            move_valid <= access && apb_req.pwrite && (apb_req.paddr == REG_MOVE);
            if (access && apb_req.pwrite)
            begin
                case (apb_req.paddr)
                    REG_CTRL:     player_q <= apb_req.pwdata[0];
                    REG_AVAIL_LO: avail_lo <= apb_req.pwdata;
                    REG_AVAIL_HI: avail_hi <= apb_req.pwdata;
                    default:      ;
                endcase
            end
        end
    end

    // move payload, qualified by move_valid
    always_ff @(posedge clock)
    begin
        if (access && apb_req.pwrite && (apb_req.paddr == REG_MOVE))
        begin
            move_from   <= apb_req.pwdata[5:0];
            move_to     <= apb_req.pwdata[13:8];
            move_placed <= apb_req.pwdata[19:16];  // side in bit 19
        end
    end

    assign move   = '{valid: move_valid, from: move_from, to: move_to, placed: move_placed};
    assign avail  = {avail_hi, avail_lo};
    assign player = player_q;

endmodule

//--- logic/chess_display_top.sv
`timescale 1ns/1ns

module chess_display_top
    import chess_pkg::*;
#(
    parameter int SCREEN_WIDTH = 96,
    parameter int BOARD_LEFT   = 16
)
(
    input  logic       clock,
    input  logic       rst_n,
    input  apb_req_t   apb_req,
    output apb_rsp_t   apb_rsp,
    input  logic       pixel_req,
    input  pixel_idx_t pixel_index,
    output logic       pixel_valid,
    output rgb565_t    pixel_colour
);

    move_cmd_t   move;
    avail_mask_t avail;
    logic        player;
    square_idx_t bus_sq_addr;
    square_t     bus_sq_data;
    square_idx_t render_sq_addr;
    square_t     render_sq_data;

    apb_board_regs u_regs (
        .clock       (clock),
        .rst_n       (rst_n),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .move        (move),
        .avail       (avail),
        .player      (player),
        .bus_sq_addr (bus_sq_addr),
        .bus_sq_data (bus_sq_data)
    );

    board_state u_board (
        .clock          (clock),
        .rst_n          (rst_n),
        .move           (move),
        .bus_sq_addr    (bus_sq_addr),
        .bus_sq_data    (bus_sq_data),
        .render_sq_addr (render_sq_addr),
        .render_sq_data (render_sq_data)
    );

    pixel_renderer #(
        .SCREEN_WIDTH (SCREEN_WIDTH),
        .BOARD_LEFT   (BOARD_LEFT)
    ) u_renderer (
        .clock        (clock),
        .rst_n        (rst_n),
        .pixel_req    (pixel_req),
        .pixel_index  (pixel_index),
        .player       (player),
        .avail        (avail),
        .sq_addr      (render_sq_addr),
        .sq_data      (render_sq_data),
        .pixel_valid  (pixel_valid),
        .pixel_colour (pixel_colour)
    );

endmodule

//--- tests/chess_display_tb.sv
`timescale 1ns/1ns

module chess_display_tb
    import chess_pkg::*;
();

    logic       clock;
    logic       rst_n;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    logic       pixel_req;
    pixel_idx_t pixel_index;
    logic       pixel_valid;
    rgb565_t    pixel_colour;

    // parsed stimulus with one entry per command line
    logic [7:0]  cmd_q [$];
    logic [31:0] arg_a_q [$];
    logic [31:0] arg_b_q [$];
    logic [31:0] arg_c_q [$];

    // pixel results still in flight
    logic [15:0] exp_colour_q [$];
    int          issue_cycle_q [$];

    int cycle_count = 0;
    int cycle_limit = 0;
    int apb_errors = 0;
    int pixel_errors = 0;
    int other_errors = 0;

    chess_display_top #(
        .SCREEN_WIDTH (96),
        .BOARD_LEFT   (16)
    ) dut (
        .clock        (clock),
        .rst_n        (rst_n),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .pixel_req    (pixel_req),
        .pixel_index  (pixel_index),
        .pixel_valid  (pixel_valid),
        .pixel_colour (pixel_colour)
    );

    initial clock = 1'b0;
    always #2 clock = ~clock;   // 4 ns period

    //////////////////////////////////////////////////////////////////////
    // cycle counter and run limit

    always @(posedge clock)
    begin
        cycle_count++;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            print_counts();
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic print_counts();
        $display("errors: apb %0d, pixel %0d, other %0d",
                 apb_errors, pixel_errors, other_errors);
    endtask

    //////////////////////////////////////////////////////////////////////
    // pixel result monitor

    always @(negedge clock)
    begin
        logic [15:0] exp_colour;
        int          issued;
        if (rst_n && pixel_valid)
        begin
            assert (exp_colour_q.size() != 0)
            else
            begin
                $display("pixel_valid went high with no pixel request outstanding");
                other_errors++;
            end
            if (exp_colour_q.size() != 0)
            begin
                exp_colour = exp_colour_q.pop_front();
                issued     = issue_cycle_q.pop_front();
                assert (pixel_colour == exp_colour)
                else
                begin
                    $display("ERROR pixel_colour expected 'h%04h got 'h%04h",
                             exp_colour, pixel_colour);
                    pixel_errors++;
                end
                assert (cycle_count - issued == 2)
                else
                begin
                    $display("ERROR pixel_valid latency expected 'h2 got 'h%0h",
                             cycle_count - issued);
                    pixel_errors++;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // drivers

    // setup phase then access phase then idle
    task automatic apb_access(input logic write, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(posedge clock);
        #1;
        pixel_req       = 1'b0;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clock);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clock);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        assert (apb_rsp.pready == 1'b1)
        else
        begin
            $display("ERROR pready at 'h%03h expected 'h1 got 'h%0h", addr, apb_rsp.pready);
            apb_errors++;
        end
        @(posedge clock);
        #1;
        apb_req = '0;
    endtask

    task automatic apb_check(input logic write, input logic [11:0] addr,
                             input logic [31:0] data, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(write, addr, data, rdata, err);
        if (!write)
        begin
            assert (rdata == data)
            else
            begin
                $display("ERROR prdata at 'h%03h expected 'h%08h got 'h%08h",
                         addr, data, rdata);
                apb_errors++;
            end
        end
        assert (err == exp_err)
        else
        begin
            $display("ERROR pslverr at 'h%03h expected 'h%0h got 'h%0h", addr, exp_err, err);
            apb_errors++;
        end
    endtask

    task automatic pixel_issue(input logic [12:0] idx, input logic [15:0] colour);
        @(posedge clock);
        #1;
        pixel_req   = 1'b1;
        pixel_index = idx;
        exp_colour_q.push_back(colour);
        issue_cycle_q.push_back(cycle_count);
    endtask

    task automatic read_stimulus();
        int          fd;
        int          n;
        logic [7:0]  cmd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        reg [8*120-1:0] rest;
        fd = $fopen("tests/chess_display_input.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the stimulus file tests/chess_display_input.txt");
            other_errors++;
            return;
        end
        while (!$feof(fd))
        begin
            n = $fscanf(fd, " %c", cmd);
            if (n != 1)
                break;
            a = '0;
            b = '0;
            c = '0;
            if (cmd == "#")
                n = $fgets(rest, fd);   // comment line
            else
            begin
                if (cmd == "P")
                    n = $fscanf(fd, "%h %h", a, b);
                else
                    n = $fscanf(fd, "%h %h %h", a, b, c);
                cmd_q.push_back(cmd);
                arg_a_q.push_back(a);
                arg_b_q.push_back(b);
                arg_c_q.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence

    initial
    begin
        rst_n       = 1'b0;
        apb_req     = '0;
        pixel_req   = 1'b0;
        pixel_index = '0;
        read_stimulus();
        cycle_limit = 16 + 8 * cmd_q.size() + 100;

        repeat (16) @(posedge clock);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < cmd_q.size(); i++)
        begin
            case (cmd_q[i])
                "W": apb_check(1'b1, arg_a_q[i][11:0], arg_b_q[i], arg_c_q[i][0]);
                "R": apb_check(1'b0, arg_a_q[i][11:0], arg_b_q[i], arg_c_q[i][0]);
                "P": pixel_issue(arg_a_q[i][12:0], arg_b_q[i][15:0]);
                default:
                begin
                    $display("unknown command '%c' in the stimulus file", cmd_q[i]);
                    other_errors++;
                end
            endcase
        end

        @(posedge clock);
        #1;
        pixel_req = 1'b0;
        while (exp_colour_q.size() != 0)
            @(posedge clock);
        repeat (4) @(posedge clock);   // catch stray pixel_valid

        print_counts();
        if (apb_errors + pixel_errors + other_errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- sources.f
logic/chess_pkg.sv
logic/piece_glyph_rom.sv
logic/pixel_renderer.sv
logic/board_state.sv
logic/apb_board_regs.sv
logic/chess_display_top.sv
tests/chess_display_tb.sv

//--- tests/chess_display_input.txt
# W offset data expect_err | R offset expected expect_err | P index expected_colour
# all values hex, pixel index = y * 96 + x
R 000 00000000 0
R 008 00000000 0
R 10C 0000000E 0
P 0000 0000
P 0010 FFFF
P 0018 9262
P 17B1 26DD
P 17B0 9262
W 004 00012434 0
R 1D0 00000000 0
R 190 00000001 0
W 004 000D1B1B 0
R 16C 0000000D 0
W 100 0000000F 1
R 100 0000000C 0
R 020 00000000 1
W 020 00000001 1
W 008 00000001 0
W 00C 00000100 0
R 00C 00000100 0
P 02B1 F7E2
P 0F10 F7E2
W 000 00000001 0
P 02B1 26DD
P 0F10 9262
